// File: compile.f
verilog/backend_pkg.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/reg_file.sv
verilog/backend_top.sv
dv/clk_gen.sv
dv/backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the back end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module backend_tb -f compile.f -o backend_sim

# a failing run stops with a non-zero status, the log decides the result
./obj_dir/backend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  exit 1
fi
exit 0

// File: dv/backend_tb.sv
// back end testbench
`timescale 1ns/10ps

module backend_tb;

  localparam int NUM_INSTS = 400;
  localparam int MAX_CYCLES = 1000;

  typedef struct {
    logic                                valid;
    logic [backend_pkg::PC_WD-1:0]       pc;
    logic [backend_pkg::INST_WD-1:0]     inst;
    backend_pkg::mem_op_e                op;
    logic [backend_pkg::WORD_WD-1:0]     alu;
    logic [backend_pkg::WORD_WD-1:0]     sdata;
    logic                                gwen;
    logic [backend_pkg::GPR_ADDR_WD-1:0] rd;
    logic                                cwen;
    logic [backend_pkg::CSR_ADDR_WD-1:0] caddr;
    logic [backend_pkg::WORD_WD-1:0]     cdata;
    logic [backend_pkg::WORD_WD-1:0]     result;
  } inst_t;

  logic clk;
  logic i_reset;
  logic i_es_valid;
  logic [31:0] i_es_pc;
  logic [31:0] i_es_inst;
  backend_pkg::mem_op_e i_es_mem_op;
  logic [31:0] i_es_alu_result;
  logic [31:0] i_es_store_data;
  logic i_es_gpr_wen;
  logic [4:0] i_es_rd;
  logic i_es_csr_wen;
  logic [11:0] i_es_csr_addr;
  logic [31:0] i_es_csr_wdata;
  logic [4:0] i_rs1;
  logic [4:0] i_rs2;
  logic [11:0] i_csr_raddr;
  logic [31:0] o_rs1_data;
  logic [31:0] o_rs2_data;
  logic [31:0] o_csr_rdata;
  logic [4:0] o_bypass_rd;
  logic [31:0] o_bypass_gpr_data;
  logic [11:0] o_bypass_csr_addr;
  logic [31:0] o_bypass_csr_data;
  logic o_commit_valid;
  logic [31:0] o_commit_pc;
  logic [31:0] o_commit_inst;
  logic o_commit_memen;
  logic [31:0] o_commit_memaddr;

  // shadow state and the two pipeline slots in flight
  logic [31:0] gpr_model [0:31];
  logic [31:0] csr_model [0:3];
  logic [31:0] ram_model [0:255];
  inst_t pipe [$];
  logic started = 1'b0;
  int cycles = 0;

  clk_gen clk_gen_i (.o_clk(clk), .o_reset(i_reset));

  backend_top backend_top_i (.*, .i_clk(clk));

  function automatic int csr_index(input logic [11:0] addr);
    case (addr)
      backend_pkg::CSR_MSTATUS: return 0;
      backend_pkg::CSR_MTVEC:   return 1;
      backend_pkg::CSR_MEPC:    return 2;
      backend_pkg::CSR_MCAUSE:  return 3;
      default:                  return -1;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // reference model, advanced on the same edges as the DUT
  always @(posedge clk) begin
    inst_t e;
    inst_t m;
    started <= 1'b1;
    if (i_reset) begin
      for (int i = 0; i < 32; i++) gpr_model[i] = '0;
      for (int i = 0; i < 4; i++) csr_model[i] = '0;
      pipe.delete();
    end else begin
      if (pipe.size() == 2 && pipe[0].valid) begin
        if (pipe[0].gwen && pipe[0].rd != 0) gpr_model[pipe[0].rd] = pipe[0].result;
        if (pipe[0].cwen && csr_index(pipe[0].caddr) >= 0)
          csr_model[csr_index(pipe[0].caddr)] = pipe[0].cdata;
      end
      if (pipe.size() >= 1 && pipe[pipe.size()-1].valid) begin
        m = pipe[pipe.size()-1];
        if (m.op == backend_pkg::MEM_LOAD) m.result = ram_model[m.alu[9:2]];
        if (m.op == backend_pkg::MEM_STORE) ram_model[m.alu[9:2]] = m.sdata;
        pipe[pipe.size()-1] = m;
      end
      if (pipe.size() == 2) void'(pipe.pop_front());
    end
    e.valid = i_es_valid && !i_reset;
    e.pc = i_es_pc;
    e.inst = i_es_inst;
    e.op = i_es_mem_op;
    e.alu = i_es_alu_result;
    e.sdata = i_es_store_data;
    e.gwen = i_es_gpr_wen;
    e.rd = i_es_rd;
    e.cwen = i_es_csr_wen;
    e.caddr = i_es_csr_addr;
    e.cdata = i_es_csr_wdata;
    e.result = i_es_alu_result;
    pipe.push_back(e);
  end

  // outputs are compared mid-cycle where they are stable
  always @(negedge clk) begin
    inst_t w;
    int ci;
    if (started) begin
      w.valid = 1'b0;
      if (pipe.size() == 2) w = pipe[0];
      check_value("o_commit_valid", o_commit_valid, w.valid);
      if (w.valid) begin
        check_value("o_commit_pc", o_commit_pc, w.pc);
        check_value("o_commit_inst", o_commit_inst, w.inst);
        check_value("o_commit_memen", o_commit_memen, w.op != backend_pkg::MEM_NONE);
        check_value("o_commit_memaddr", o_commit_memaddr, w.alu);
      end
      check_value("o_bypass_rd", o_bypass_rd, (w.valid && w.gwen) ? w.rd : 0);
      check_value("o_bypass_gpr_data", o_bypass_gpr_data, (w.valid && w.gwen) ? w.result : 0);
      check_value("o_bypass_csr_addr", o_bypass_csr_addr, (w.valid && w.cwen) ? w.caddr : 0);
      check_value("o_bypass_csr_data", o_bypass_csr_data, (w.valid && w.cwen) ? w.cdata : 0);
      check_value("o_rs1_data", o_rs1_data, gpr_model[i_rs1]);
      check_value("o_rs2_data", o_rs2_data, gpr_model[i_rs2]);
      ci = csr_index(i_csr_raddr);
      check_value("o_csr_rdata", o_csr_rdata, (ci >= 0) ? csr_model[ci] : 0);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the run did not end within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin
    logic written [0:255];
    logic [11:0] csr_pick [0:4];
    logic [31:0] addr;
    logic [31:0] last_store;
    logic prev_store;
    int r;
    void'($urandom(73));
    csr_pick = '{12'h300, 12'h305, 12'h341, 12'h342, 12'h123};
    for (int i = 0; i < 256; i++) written[i] = 1'b0;
    prev_store = 1'b0;
    last_store = '0;
    i_es_valid = 1'b0;
    i_es_pc = '0;
    i_es_inst = '0;
    i_es_mem_op = backend_pkg::MEM_NONE;
    i_es_alu_result = '0;
    i_es_store_data = '0;
    i_es_gpr_wen = 1'b0;
    i_es_rd = '0;
    i_es_csr_wen = 1'b0;
    i_es_csr_addr = '0;
    i_es_csr_wdata = '0;
    i_rs1 = '0;
    i_rs2 = '0;
    i_csr_raddr = '0;
    @(posedge clk);
    // random read addresses while reset is held
    while (i_reset) begin
      i_rs1 <= $urandom;
      i_rs2 <= $urandom;
      i_csr_raddr <= csr_pick[$urandom % 5];
      @(posedge clk);
    end
    for (int n = 0; n < NUM_INSTS; n++) begin
      r = $urandom % 8;
      addr = {$urandom} & 32'h0000_03fc;
      i_es_valid <= ($urandom % 4) != 0;
      i_es_pc <= 32'h8000_0000 + n * 4;
      i_es_inst <= $urandom;
      i_es_store_data <= $urandom;
      i_es_rd <= $urandom;
      i_es_csr_wen <= ($urandom % 4) == 0;
      i_es_csr_addr <= csr_pick[$urandom % 5];
      i_es_csr_wdata <= $urandom;
      i_rs1 <= $urandom;
      i_rs2 <= $urandom;
      i_csr_raddr <= csr_pick[$urandom % 5];
      // load right behind a store to the same word
      if (prev_store && ($urandom % 2) == 0) begin
        addr = last_store;
        r = 2;
        i_es_valid <= 1'b1;
      end
      prev_store = 1'b0;
      if (r < 2) begin
        i_es_mem_op <= backend_pkg::MEM_STORE;
        i_es_gpr_wen <= 1'b0;
        i_es_valid <= 1'b1;
        i_es_alu_result <= addr;
        written[addr[9:2]] = 1'b1;
        last_store = addr;
        prev_store = 1'b1;
      end else if (r < 4 && written[addr[9:2]]) begin
        i_es_mem_op <= backend_pkg::MEM_LOAD;
        i_es_gpr_wen <= 1'b1;
        i_es_alu_result <= addr;
      end else begin
        i_es_mem_op <= backend_pkg::MEM_NONE;
        i_es_gpr_wen <= ($urandom % 4) != 0;
        i_es_alu_result <= $urandom;
      end
      @(posedge clk);
    end
    i_es_valid <= 1'b0;
    repeat (4) @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: dv/clk_gen.sv
// testbench clock and reset
`timescale 1ns/10ps

module clk_gen (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;
  end

  // reset held over the first two rising edges
  initial begin
    o_reset = 1'b1;
    repeat (2) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

// File: verilog/backend_top.sv
// pipeline back end top
`timescale 1ns/10ps

module backend_top (
  input  logic                                i_clk,
  input  logic                                i_reset,
  // from execute
  input  logic                                i_es_valid,
  input  logic [backend_pkg::PC_WD-1:0]       i_es_pc,
  input  logic [backend_pkg::INST_WD-1:0]     i_es_inst,
  input  backend_pkg::mem_op_e                i_es_mem_op,
  input  logic [backend_pkg::WORD_WD-1:0]     i_es_alu_result,
  input  logic [backend_pkg::WORD_WD-1:0]     i_es_store_data,
  input  logic                                i_es_gpr_wen,
  input  logic [backend_pkg::GPR_ADDR_WD-1:0] i_es_rd,
  input  logic                                i_es_csr_wen,
  input  logic [backend_pkg::CSR_ADDR_WD-1:0] i_es_csr_addr,
  input  logic [backend_pkg::WORD_WD-1:0]     i_es_csr_wdata,
  // register file reads
  input  logic [backend_pkg::GPR_ADDR_WD-1:0] i_rs1,
  input  logic [backend_pkg::GPR_ADDR_WD-1:0] i_rs2,
  input  logic [backend_pkg::CSR_ADDR_WD-1:0] i_csr_raddr,
  output logic [backend_pkg::WORD_WD-1:0]     o_rs1_data,
  output logic [backend_pkg::WORD_WD-1:0]     o_rs2_data,
  output logic [backend_pkg::WORD_WD-1:0]     o_csr_rdata,
  // bypass
  output logic [backend_pkg::GPR_ADDR_WD-1:0] o_bypass_rd,
  output logic [backend_pkg::WORD_WD-1:0]     o_bypass_gpr_data,
  output logic [backend_pkg::CSR_ADDR_WD-1:0] o_bypass_csr_addr,
  output logic [backend_pkg::WORD_WD-1:0]     o_bypass_csr_data,
  // commit trace
  output logic                                o_commit_valid,
  output logic [backend_pkg::PC_WD-1:0]       o_commit_pc,
  output logic [backend_pkg::INST_WD-1:0]     o_commit_inst,
  output logic                                o_commit_memen,
  output logic [backend_pkg::WORD_WD-1:0]     o_commit_memaddr
);

  logic                                ms_valid;
  logic [backend_pkg::PC_WD-1:0]       ms_pc;
  logic [backend_pkg::INST_WD-1:0]     ms_inst;
  logic                                ms_gpr_wen;
  logic [backend_pkg::GPR_ADDR_WD-1:0] ms_rd;
  logic [backend_pkg::WORD_WD-1:0]     ms_gpr_result;
  logic                                ms_csr_wen;
  logic [backend_pkg::CSR_ADDR_WD-1:0] ms_csr_addr;
  logic [backend_pkg::WORD_WD-1:0]     ms_csr_wdata;
  logic                                ms_memen;
  logic [backend_pkg::WORD_WD-1:0]     ms_memaddr;

  logic                                gpr_we;
  logic [backend_pkg::GPR_ADDR_WD-1:0] gpr_waddr;
  logic [backend_pkg::WORD_WD-1:0]     gpr_wdata;
  logic                                csr_we;
  logic [backend_pkg::CSR_ADDR_WD-1:0] csr_waddr;
  logic [backend_pkg::WORD_WD-1:0]     csr_wdata;

  mem_stage mem_stage_i (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_es_valid      (i_es_valid),
    .i_es_pc         (i_es_pc),
    .i_es_inst       (i_es_inst),
    .i_es_mem_op     (i_es_mem_op),
    .i_es_alu_result (i_es_alu_result),
    .i_es_store_data (i_es_store_data),
    .i_es_gpr_wen    (i_es_gpr_wen),
    .i_es_rd         (i_es_rd),
    .i_es_csr_wen    (i_es_csr_wen),
    .i_es_csr_addr   (i_es_csr_addr),
    .i_es_csr_wdata  (i_es_csr_wdata),
    .o_ms_valid      (ms_valid),
    .o_ms_pc         (ms_pc),
    .o_ms_inst       (ms_inst),
    .o_ms_gpr_wen    (ms_gpr_wen),
    .o_ms_rd         (ms_rd),
    .o_ms_gpr_result (ms_gpr_result),
    .o_ms_csr_wen    (ms_csr_wen),
    .o_ms_csr_addr   (ms_csr_addr),
    .o_ms_csr_wdata  (ms_csr_wdata),
    .o_ms_memen      (ms_memen),
    .o_ms_memaddr    (ms_memaddr)
  );

  wb_stage wb_stage_i (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_ms_valid        (ms_valid),
    .i_ms_pc           (ms_pc),
    .i_ms_inst         (ms_inst),
    .i_ms_gpr_wen      (ms_gpr_wen),
    .i_ms_rd           (ms_rd),
    .i_ms_gpr_result   (ms_gpr_result),
    .i_ms_csr_wen      (ms_csr_wen),
    .i_ms_csr_addr     (ms_csr_addr),
    .i_ms_csr_wdata    (ms_csr_wdata),
    .i_ms_memen        (ms_memen),
    .i_ms_memaddr      (ms_memaddr),
    .o_gpr_we          (gpr_we),
    .o_gpr_waddr       (gpr_waddr),
    .o_gpr_wdata       (gpr_wdata),
    .o_csr_we          (csr_we),
    .o_csr_waddr       (csr_waddr),
    .o_csr_wdata       (csr_wdata),
    .o_bypass_rd       (o_bypass_rd),
    .o_bypass_gpr_data (o_bypass_gpr_data),
    .o_bypass_csr_addr (o_bypass_csr_addr),
    .o_bypass_csr_data (o_bypass_csr_data),
    .o_commit_valid    (o_commit_valid),
    .o_commit_pc       (o_commit_pc),
    .o_commit_inst     (o_commit_inst),
    .o_commit_memen    (o_commit_memen),
    .o_commit_memaddr  (o_commit_memaddr)
  );

  reg_file reg_file_i (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_gpr_we    (gpr_we),
    .i_gpr_waddr (gpr_waddr),
    .i_gpr_wdata (gpr_wdata),
    .i_csr_we    (csr_we),
    .i_csr_waddr (csr_waddr),
    .i_csr_wdata (csr_wdata),
    .i_rs1       (i_rs1),
    .o_rs1_data  (o_rs1_data),
    .i_rs2       (i_rs2),
    .o_rs2_data  (o_rs2_data),
    .i_csr_raddr (i_csr_raddr),
    .o_csr_rdata (o_csr_rdata)
  );

endmodule

// File: verilog/reg_file.sv
// register file with machine csrs
`timescale 1ns/10ps

module reg_file (
  input  logic                                i_clk,
  input  logic                                i_reset,
  // gpr write
  input  logic                                i_gpr_we,
  input  logic [backend_pkg::GPR_ADDR_WD-1:0] i_gpr_waddr,
  input  logic [backend_pkg::WORD_WD-1:0]     i_gpr_wdata,
  // csr write
  input  logic                                i_csr_we,
  input  logic [backend_pkg::CSR_ADDR_WD-1:0] i_csr_waddr,
  input  logic [backend_pkg::WORD_WD-1:0]     i_csr_wdata,
  // read ports
  input  logic [backend_pkg::GPR_ADDR_WD-1:0] i_rs1,
  output logic [backend_pkg::WORD_WD-1:0]     o_rs1_data,
  input  logic [backend_pkg::GPR_ADDR_WD-1:0] i_rs2,
  output logic [backend_pkg::WORD_WD-1:0]     o_rs2_data,
  input  logic [backend_pkg::CSR_ADDR_WD-1:0] i_csr_raddr,
  output logic [backend_pkg::WORD_WD-1:0]     o_csr_rdata
);

  logic [backend_pkg::WORD_WD-1:0] gpr [0:(2**backend_pkg::GPR_ADDR_WD)-1];
  logic [backend_pkg::WORD_WD-1:0] mstatus;
  logic [backend_pkg::WORD_WD-1:0] mtvec;
  logic [backend_pkg::WORD_WD-1:0] mepc;
  logic [backend_pkg::WORD_WD-1:0] mcause;

  // x0 is never written
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 2**backend_pkg::GPR_ADDR_WD; i++) begin
        gpr[i] <= '0;
      end
    end else if (i_gpr_we && (i_gpr_waddr != '0)) begin
      gpr[i_gpr_waddr] <= i_gpr_wdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_csr_we) begin
      case (i_csr_waddr)
        backend_pkg::CSR_MSTATUS: mstatus <= i_csr_wdata;
        backend_pkg::CSR_MTVEC:   mtvec   <= i_csr_wdata;
        backend_pkg::CSR_MEPC:    mepc    <= i_csr_wdata;
        backend_pkg::CSR_MCAUSE:  mcause  <= i_csr_wdata;
        default: begin
        end
      endcase
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : gpr[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : gpr[i_rs2];

  // unimplemented csrs read as zero
  always_comb begin
    case (i_csr_raddr)
      backend_pkg::CSR_MSTATUS: o_csr_rdata = mstatus;
      backend_pkg::CSR_MTVEC:   o_csr_rdata = mtvec;
      backend_pkg::CSR_MEPC:    o_csr_rdata = mepc;
      backend_pkg::CSR_MCAUSE:  o_csr_rdata = mcause;
      default:                  o_csr_rdata = '0;
    endcase
  end

endmodule

// File: verilog/wb_stage.sv
// write back stage
`timescale 1ns/10ps

module wb_stage (
  input  logic                                i_clk,
  input  logic                                i_reset,
  // from memory stage
  input  logic                                i_ms_valid,
  input  logic [backend_pkg::PC_WD-1:0]       i_ms_pc,
  input  logic [backend_pkg::INST_WD-1:0]     i_ms_inst,
  input  logic                                i_ms_gpr_wen,
  input  logic [backend_pkg::GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [backend_pkg::WORD_WD-1:0]     i_ms_gpr_result,
  input  logic                                i_ms_csr_wen,
  input  logic [backend_pkg::CSR_ADDR_WD-1:0] i_ms_csr_addr,
  input  logic [backend_pkg::WORD_WD-1:0]     i_ms_csr_wdata,
  input  logic                                i_ms_memen,
  input  logic [backend_pkg::WORD_WD-1:0]     i_ms_memaddr,
  // to register file
  output logic                                o_gpr_we,
  output logic [backend_pkg::GPR_ADDR_WD-1:0] o_gpr_waddr,
  output logic [backend_pkg::WORD_WD-1:0]     o_gpr_wdata,
  output logic                                o_csr_we,
  output logic [backend_pkg::CSR_ADDR_WD-1:0] o_csr_waddr,
  output logic [backend_pkg::WORD_WD-1:0]     o_csr_wdata,
  // bypass to decode
  output logic [backend_pkg::GPR_ADDR_WD-1:0] o_bypass_rd,
  output logic [backend_pkg::WORD_WD-1:0]     o_bypass_gpr_data,
  output logic [backend_pkg::CSR_ADDR_WD-1:0] o_bypass_csr_addr,
  output logic [backend_pkg::WORD_WD-1:0]     o_bypass_csr_data,
  // commit trace
  output logic                                o_commit_valid,
  output logic [backend_pkg::PC_WD-1:0]       o_commit_pc,
  output logic [backend_pkg::INST_WD-1:0]     o_commit_inst,
  output logic                                o_commit_memen,
  output logic [backend_pkg::WORD_WD-1:0]     o_commit_memaddr
);

  logic                                ws_valid;
  logic [backend_pkg::PC_WD-1:0]       ws_pc_r;
  logic [backend_pkg::INST_WD-1:0]     ws_inst_r;
  logic                                ws_gpr_wen_r;
  logic [backend_pkg::GPR_ADDR_WD-1:0] ws_rd_r;
  logic [backend_pkg::WORD_WD-1:0]     ws_gpr_result_r;
  logic                                ws_csr_wen_r;
  logic [backend_pkg::CSR_ADDR_WD-1:0] ws_csr_addr_r;
  logic [backend_pkg::WORD_WD-1:0]     ws_csr_wdata_r;
  logic                                ws_memen_r;
  logic [backend_pkg::WORD_WD-1:0]     ws_memaddr_r;

  logic                                gpr_act;
  logic                                csr_act;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ws_valid <= 1'b0;
    end else begin
      ws_valid <= i_ms_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ms_valid) begin
      ws_pc_r         <= i_ms_pc;
      ws_inst_r       <= i_ms_inst;
      ws_gpr_wen_r    <= i_ms_gpr_wen;
      ws_rd_r         <= i_ms_rd;
      ws_gpr_result_r <= i_ms_gpr_result;
      ws_csr_wen_r    <= i_ms_csr_wen;
      ws_csr_addr_r   <= i_ms_csr_addr;
      ws_csr_wdata_r  <= i_ms_csr_wdata;
      ws_memen_r      <= i_ms_memen;
      ws_memaddr_r    <= i_ms_memaddr;
    end
  end

  assign gpr_act = ws_valid && ws_gpr_wen_r;
  assign csr_act = ws_valid && ws_csr_wen_r;

  assign o_gpr_we    = gpr_act;
  assign o_gpr_waddr = ws_rd_r;
  assign o_gpr_wdata = ws_gpr_result_r;
  assign o_csr_we    = csr_act;
  assign o_csr_waddr = ws_csr_addr_r;
  assign o_csr_wdata = ws_csr_wdata_r;

  // zero fields mean nothing to forward
  assign o_bypass_rd       = gpr_act ? ws_rd_r : '0;
  assign o_bypass_gpr_data = gpr_act ? ws_gpr_result_r : '0;
  assign o_bypass_csr_addr = csr_act ? ws_csr_addr_r : '0;
  assign o_bypass_csr_data = csr_act ? ws_csr_wdata_r : '0;

  assign o_commit_valid   = ws_valid;
  assign o_commit_pc      = ws_pc_r;
  assign o_commit_inst    = ws_inst_r;
  assign o_commit_memen   = ws_memen_r;
  assign o_commit_memaddr = ws_memaddr_r;

endmodule

// File: verilog/mem_stage.sv
// memory stage
`timescale 1ns/10ps

module mem_stage (
  input  logic                                i_clk,
  input  logic                                i_reset,
  // from execute
  input  logic                                i_es_valid,
  input  logic [backend_pkg::PC_WD-1:0]       i_es_pc,
  input  logic [backend_pkg::INST_WD-1:0]     i_es_inst,
  input  backend_pkg::mem_op_e                i_es_mem_op,
  input  logic [backend_pkg::WORD_WD-1:0]     i_es_alu_result,
  input  logic [backend_pkg::WORD_WD-1:0]     i_es_store_data,
  input  logic                                i_es_gpr_wen,
  input  logic [backend_pkg::GPR_ADDR_WD-1:0] i_es_rd,
  input  logic                                i_es_csr_wen,
  input  logic [backend_pkg::CSR_ADDR_WD-1:0] i_es_csr_addr,
  input  logic [backend_pkg::WORD_WD-1:0]     i_es_csr_wdata,
  // to write back
  output logic                                o_ms_valid,
  output logic [backend_pkg::PC_WD-1:0]       o_ms_pc,
  output logic [backend_pkg::INST_WD-1:0]     o_ms_inst,
  output logic                                o_ms_gpr_wen,
  output logic [backend_pkg::GPR_ADDR_WD-1:0] o_ms_rd,
  output logic [backend_pkg::WORD_WD-1:0]     o_ms_gpr_result,
  output logic                                o_ms_csr_wen,
  output logic [backend_pkg::CSR_ADDR_WD-1:0] o_ms_csr_addr,
  output logic [backend_pkg::WORD_WD-1:0]     o_ms_csr_wdata,
  output logic                                o_ms_memen,
  output logic [backend_pkg::WORD_WD-1:0]     o_ms_memaddr
);

  logic                                ms_valid;
  logic [backend_pkg::PC_WD-1:0]       ms_pc_r;
  logic [backend_pkg::INST_WD-1:0]     ms_inst_r;
  backend_pkg::mem_op_e                ms_mem_op_r;
  logic [backend_pkg::WORD_WD-1:0]     ms_alu_result_r;
  logic [backend_pkg::WORD_WD-1:0]     ms_store_data_r;
  logic                                ms_gpr_wen_r;
  logic [backend_pkg::GPR_ADDR_WD-1:0] ms_rd_r;
  logic                                ms_csr_wen_r;
  logic [backend_pkg::CSR_ADDR_WD-1:0] ms_csr_addr_r;
  logic [backend_pkg::WORD_WD-1:0]     ms_csr_wdata_r;

  logic                                is_load;
  logic                                is_store;
  logic                                ram_we;
  logic [backend_pkg::WORD_WD-1:0]     ram_rdata;

  // no back-pressure, valid follows the strobe every cycle
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ms_valid <= 1'b0;
    end else begin
      ms_valid <= i_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_valid) begin
      ms_pc_r         <= i_es_pc;
      ms_inst_r       <= i_es_inst;
      ms_mem_op_r     <= i_es_mem_op;
      ms_alu_result_r <= i_es_alu_result;
      ms_store_data_r <= i_es_store_data;
      ms_gpr_wen_r    <= i_es_gpr_wen;
      ms_rd_r         <= i_es_rd;
      ms_csr_wen_r    <= i_es_csr_wen;
      ms_csr_addr_r   <= i_es_csr_addr;
      ms_csr_wdata_r  <= i_es_csr_wdata;
    end
  end

  assign is_load  = (ms_mem_op_r == backend_pkg::MEM_LOAD);
  assign is_store = (ms_mem_op_r == backend_pkg::MEM_STORE);
  assign ram_we   = ms_valid && is_store;

  // word index from the byte address
  data_ram data_ram_i (
    .i_clk   (i_clk),
    .i_we    (ram_we),
    .i_addr  (ms_alu_result_r[backend_pkg::RAM_ADDR_WD+1:2]),
    .i_wdata (ms_store_data_r),
    .o_rdata (ram_rdata)
  );

  assign o_ms_valid      = ms_valid;
  assign o_ms_pc         = ms_pc_r;
  assign o_ms_inst       = ms_inst_r;
  assign o_ms_gpr_wen    = ms_gpr_wen_r;
  assign o_ms_rd         = ms_rd_r;
  assign o_ms_gpr_result = is_load ? ram_rdata : ms_alu_result_r;
  assign o_ms_csr_wen    = ms_csr_wen_r;
  assign o_ms_csr_addr   = ms_csr_addr_r;
  assign o_ms_csr_wdata  = ms_csr_wdata_r;
  assign o_ms_memen      = is_load || is_store;
  assign o_ms_memaddr    = ms_alu_result_r;

endmodule

// File: verilog/data_ram.sv
// data memory
`timescale 1ns/10ps

module data_ram (
  input  logic                                i_clk,
  input  logic                                i_we,
  input  logic [backend_pkg::RAM_ADDR_WD-1:0] i_addr,
  input  logic [backend_pkg::WORD_WD-1:0]     i_wdata,
  output logic [backend_pkg::WORD_WD-1:0]     o_rdata
);

  logic [backend_pkg::WORD_WD-1:0] mem [0:(2**backend_pkg::RAM_ADDR_WD)-1];

  // word write on the clock edge
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
  end

  // read is combinational, so a load right after a store sees the new word
  assign o_rdata = mem[i_addr];

endmodule

// File: verilog/backend_pkg.sv
// backend shared definitions
package backend_pkg;

  // datapath widths
  localparam int WORD_WD     = 32;
  localparam int PC_WD       = 32;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;

  // data ram holds 2**RAM_ADDR_WD words
  localparam int RAM_ADDR_WD = 8;

  // implemented machine csrs
  localparam logic [CSR_ADDR_WD-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MCAUSE  = 12'h342;

  // memory operation carried with each instruction
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

endpackage
